// File: common/ig_data_pkg.sv
package ig_data_pkg;

    // --------------------
    // field widths
    // --------------------
    parameter int PIX_W  = 8;
    parameter int DIFF_W = PIX_W + 2;
    parameter int GRAD_W = 2 * DIFF_W;

    // unsigned greyscale sample
    typedef logic [PIX_W-1:0] pixel_t;

    // forward difference, -255 to +255
    typedef logic signed [DIFF_W-1:0] diff_t;

    // gx in the upper half, gy in the lower half
    typedef logic [GRAD_W-1:0] grad_t;

    // --------------------
    // helpers
    // --------------------

    // a - b, both zero-extended before the subtraction
    function automatic diff_t pix_diff(pixel_t a, pixel_t b);
        return $signed({2'b00, a}) - $signed({2'b00, b});
    endfunction

    function automatic grad_t pack_grad(diff_t gx, diff_t gy);
        return {gx, gy};
    endfunction

endpackage

// File: common/ig_ctrl_pkg.sv
package ig_ctrl_pkg;

    // --------------------
    // fetch controller
    // --------------------

    // FETCH_READ walks the raster, FETCH_HALT waits for the next reset
    typedef enum logic {
        FETCH_READ = 1'b0,
        FETCH_HALT = 1'b1
    } fetch_state_t;

endpackage

// File: gradient/line_buffer.sv
`timescale 1ns/1ps

module line_buffer
    import ig_data_pkg::*;
#(
    parameter int IMG_WIDTH = 256
) (
    input  logic   clk,
    input  logic   reset,

    // one pixel enters per shift
    input  logic   shift,
    input  pixel_t pix_in,

    // taps one row back
    output pixel_t above,
    output pixel_t above_right
);

    // --------------------
    // row delay line
    // --------------------

    // taps[0] holds the newest pixel, taps[IMG_WIDTH-1] the oldest
    pixel_t taps [IMG_WIDTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < IMG_WIDTH; i++) begin
                taps[i] <= '0;
            end
        end else if (shift) begin
            taps[0] <= pix_in;
            for (int i = 1; i < IMG_WIDTH; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    // --------------------
    // output taps
    // --------------------

    // read from the registers, so the incoming pixel is not yet in
    // the line; above is W shifts old, above_right W-1 shifts old
    assign above       = taps[IMG_WIDTH-1];
    assign above_right = taps[IMG_WIDTH-2];

endmodule

// File: gradient/grad_calc.sv
`timescale 1ns/1ps

module grad_calc
    import ig_data_pkg::*;
#(
    parameter int IMG_WIDTH = 256,
    localparam int ADDR_W = $clog2(IMG_WIDTH * IMG_WIDTH)
) (
    input  logic              clk,
    input  logic              reset,

    // pixel stream in raster order
    input  logic              pix_valid,
    input  logic [ADDR_W-1:0] pix_addr,
    input  pixel_t            pix,

    // gradient memory write
    output logic              grad_wr,
    output logic [ADDR_W-1:0] grad_addr,
    output grad_t             grad_do,

    output logic              done
);

    localparam int COL_W = $clog2(IMG_WIDTH);
    localparam int ROW_W = ADDR_W - COL_W;

    localparam logic [COL_W-1:0]  LAST_COL  = COL_W'(IMG_WIDTH - 1);
    localparam logic [ADDR_W-1:0] ROW_STEP  = ADDR_W'(IMG_WIDTH);
    localparam logic [ADDR_W-1:0] LAST_GRAD =
        ADDR_W'((IMG_WIDTH - 2) * IMG_WIDTH + (IMG_WIDTH - 2));

    logic [ROW_W-1:0] pix_row;
    logic [COL_W-1:0] pix_col;
    logic             word_en;
    pixel_t           above;
    pixel_t           above_right;
    diff_t            gx;
    diff_t            gy;

    // --------------------
    // previous row
    // --------------------
    line_buffer #(
        .IMG_WIDTH (IMG_WIDTH)
    ) u_line_buffer (
        .clk         (clk),
        .reset       (reset),
        .shift       (pix_valid),
        .pix_in      (pix),
        .above       (above),
        .above_right (above_right)
    );

    // --------------------
    // differences
    // --------------------
    assign pix_row = pix_addr[ADDR_W-1:COL_W];
    assign pix_col = pix_addr[COL_W-1:0];

    // current pixel sits one row below the word being produced,
    // so row 0 gives nothing and the last column has no right neighbour
    assign word_en = pix_valid && (pix_row != '0) && (pix_col != LAST_COL);

    assign gx = pix_diff(above_right, above);
    assign gy = pix_diff(pix, above);

    // --------------------
    // output registers
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr <= 1'b0;
            done    <= 1'b0;
        end else begin
            grad_wr <= word_en;
            // single pulse right after the final word goes out
            done    <= grad_wr && (grad_addr == LAST_GRAD);
        end
    end

    // word lands one row above the pixel that completed it
    always_ff @(posedge clk) begin
        if (word_en) begin
            grad_addr <= pix_addr - ROW_STEP;
            grad_do   <= pack_grad(gx, gy);
        end
    end

endmodule

// File: hdl/img_fetch.sv
`timescale 1ns/1ps

module img_fetch
    import ig_ctrl_pkg::*;
#(
    parameter int IMG_WIDTH = 256,
    localparam int ADDR_W = $clog2(IMG_WIDTH * IMG_WIDTH)
) (
    input  logic              clk,
    input  logic              reset,

    // image memory request
    output logic              img_rd,
    output logic [ADDR_W-1:0] img_addr,

    // request delayed to match the memory latency
    output logic              pix_valid,
    output logic [ADDR_W-1:0] pix_addr
);

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(IMG_WIDTH * IMG_WIDTH - 1);

    fetch_state_t state;

    // --------------------
    // address sequencer
    // --------------------

    // the strobe rises on the first edge out of reset and then
    // stays up for one full raster, one address per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= FETCH_READ;
            img_rd   <= 1'b0;
            img_addr <= '0;
        end else begin
            case (state)
                FETCH_READ: begin
                    if (img_rd && img_addr == LAST_ADDR) begin
                        // whole image requested
                        state  <= FETCH_HALT;
                        img_rd <= 1'b0;
                    end else begin
                        img_rd <= 1'b1;
                        if (img_rd) begin
                            img_addr <= img_addr + 1'b1;
                        end
                    end
                end
                FETCH_HALT: begin
                    img_rd <= 1'b0;
                end
                default: begin
                    state  <= FETCH_HALT;
                    img_rd <= 1'b0;
                end
            endcase
        end
    end

    // --------------------
    // read data alignment
    // --------------------

    // memory answers one cycle after the strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            pix_valid <= 1'b0;
            pix_addr  <= '0;
        end else begin
            pix_valid <= img_rd;
            pix_addr  <= img_addr;
        end
    end

endmodule

// File: hdl/ig.sv
`timescale 1ns/1ps

module ig
    import ig_data_pkg::*;
#(
    parameter int IMG_WIDTH = 256,
    localparam int ADDR_W = $clog2(IMG_WIDTH * IMG_WIDTH)
) (
    input  logic              clk,
    input  logic              reset,

    // image memory, read only
    output logic              img_rd,
    output logic [ADDR_W-1:0] img_addr,
    input  pixel_t            img_di,

    // gradient memory, write only
    output logic              grad_wr,
    output logic [ADDR_W-1:0] grad_addr,
    output grad_t             grad_do,

    output logic              done
);

    // --------------------
    // internal signals
    // --------------------

    // read strobe and address one cycle late, lined up with img_di
    logic              pix_valid;
    logic [ADDR_W-1:0] pix_addr;

    // --------------------
    // raster fetch
    // --------------------
    img_fetch #(
        .IMG_WIDTH (IMG_WIDTH)
    ) u_img_fetch (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .pix_valid (pix_valid),
        .pix_addr  (pix_addr)
    );

    // --------------------
    // gradient datapath
    // --------------------
    grad_calc #(
        .IMG_WIDTH (IMG_WIDTH)
    ) u_grad_calc (
        .clk       (clk),
        .reset     (reset),
        .pix_valid (pix_valid),
        .pix_addr  (pix_addr),
        .pix       (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    // free running, low for the first half period
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// File: test/ig_props.sv
`timescale 1ns/1ps

module ig_props #(
    parameter int IMG_WIDTH = 256,
    localparam int ADDR_W = $clog2(IMG_WIDTH * IMG_WIDTH),
    localparam int COL_W = $clog2(IMG_WIDTH)
) (
    input logic              clk,
    input logic              reset,
    input logic              img_rd,
    input logic [ADDR_W-1:0] img_addr,
    input logic              grad_wr,
    input logic [ADDR_W-1:0] grad_addr,
    input logic              done
);

    localparam logic [COL_W-1:0] LAST_IDX = COL_W'(IMG_WIDTH - 1);

    // outputs are registered, so they are low one edge into reset
    a_reset_quiet: assert property (@(posedge clk)
        $past(reset) |-> (!img_rd && !grad_wr && !done))
        else $error("strobe or done high during reset");

    a_read_step: assert property (@(posedge clk) disable iff (reset)
        (img_rd && $past(img_rd)) |-> (img_addr == ADDR_W'($past(img_addr) + 1'b1)))
        else $error("img_addr did not advance by one");

    // no word for the last row or the last column
    a_grad_range: assert property (@(posedge clk) disable iff (reset)
        grad_wr |-> (grad_addr[COL_W-1:0] != LAST_IDX
                     && grad_addr[ADDR_W-1:COL_W] != LAST_IDX))
        else $error("gradient write to the last row or column");

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("done held for more than one cycle");

endmodule

bind ig ig_props #(.IMG_WIDTH(IMG_WIDTH)) u_props (
    .clk       (clk),
    .reset     (reset),
    .img_rd    (img_rd),
    .img_addr  (img_addr),
    .grad_wr   (grad_wr),
    .grad_addr (grad_addr),
    .done      (done)
);

// File: test/ig_tb.sv
`timescale 1ns/1ps

module ig_tb
    import ig_data_pkg::*;
#(
    parameter int IMG_WIDTH = 16
);

    localparam int W            = IMG_WIDTH;
    localparam int NPIX         = W * W;
    localparam int ADDR_W       = $clog2(NPIX);
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 2;
    // six runs in all since the mid-run reset test restarts once
    localparam int TIMEOUT_NS   = 6 * (NPIX + 40) * CLK_PERIOD;

    typedef logic [ADDR_W-1:0] addr_t;

    logic   clk;
    logic   reset = 1'b1;
    logic   clear_grad = 1'b1;
    logic   img_rd;
    addr_t  img_addr;
    pixel_t img_di = '0;
    logic   grad_wr;
    addr_t  grad_addr;
    grad_t  grad_do;
    logic   done;
    int     seed;

    pixel_t img_mem  [NPIX];
    grad_t  grad_mem [NPIX];

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clock (.clk(clk));

    ig #(
        .IMG_WIDTH (W)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    // --------------------
    // memory models
    // --------------------

    // synchronous read with one cycle of latency
    always @(posedge clk) begin
        if (img_rd) begin
            img_di <= img_mem[img_addr];
        end
    end

    always @(posedge clk) begin
        if (clear_grad) begin
            for (int i = 0; i < NPIX; i++) begin
                grad_mem[i] <= '0;
            end
        end else if (grad_wr) begin
            grad_mem[grad_addr] <= grad_do;
        end
    end

    // --------------------
    // compare tasks
    // --------------------
    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_grad(addr_t addr, grad_t exp, grad_t act);
        if (act !== exp) begin
            $display("FAILED at %0d ns: grad_mem[%0d] expected %h, got %h",
                     $time, addr, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("FAILED at %0d ns: %s expected %b, got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(string name, addr_t exp, addr_t act);
        if (act !== exp) begin
            $display("FAILED at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            $display("FAILED at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    // --------------------
    // stimulus helpers
    // --------------------
    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        clear_grad = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        clear_grad = 1'b0;
    endtask

    task automatic wait_done();
        do begin
            @(negedge clk);
        end while (done !== 1'b1);
    endtask

    task automatic fill_ramp();
        for (int r = 0; r < W; r++) begin
            for (int c = 0; c < W; c++) begin
                img_mem[addr_t'(r * W + c)] = pixel_t'(3 * c + 5 * r);
            end
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < NPIX; i++) begin
            img_mem[addr_t'(i)] = pixel_t'($random(seed));
        end
    endtask

    task automatic fill_checker();
        for (int r = 0; r < W; r++) begin
            for (int c = 0; c < W; c++) begin
                img_mem[addr_t'(r * W + c)] = ((r + c) % 2 == 1) ? 8'hff : 8'h00;
            end
        end
    endtask

    // reference word straight from the forward difference rule
    function automatic grad_t expected_word(int r, int c);
        diff_t gx;
        diff_t gy;
        gx = diff_t'(int'(img_mem[addr_t'(r * W + c + 1)])
                     - int'(img_mem[addr_t'(r * W + c)]));
        gy = diff_t'(int'(img_mem[addr_t'((r + 1) * W + c)])
                     - int'(img_mem[addr_t'(r * W + c)]));
        return {gx, gy};
    endfunction

    // last row and column must stay cleared
    task automatic verify_grads(bit fixed_ramp);
        grad_t exp;
        for (int r = 0; r < W; r++) begin
            for (int c = 0; c < W; c++) begin
                if (r == W - 1 || c == W - 1) begin
                    exp = '0;
                end else if (fixed_ramp) begin
                    exp = {diff_t'(3), diff_t'(5)};
                end else begin
                    exp = expected_word(r, c);
                end
                check_grad(addr_t'(r * W + c), exp, grad_mem[addr_t'(r * W + c)]);
            end
        end
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic test_image(int kind);
        if (kind == 0) begin
            fill_ramp();
        end else if (kind == 1) begin
            fill_random();
        end else begin
            fill_checker();
        end
        apply_reset();
        wait_done();
        verify_grads(kind == 0);
    endtask

    task automatic test_write_pattern();
        int   reads;
        int   writes;
        int   dones;
        logic prev_wr;
        reads = 0;
        writes = 0;
        dones = 0;
        prev_wr = 1'b0;
        fill_random();
        apply_reset();
        while (dones == 0) begin
            @(negedge clk);
            if (img_rd) begin
                check_addr("img_addr", addr_t'(reads), img_addr);
                reads++;
            end
            if (grad_wr) begin
                check_addr("grad_addr", addr_t'((writes / (W - 1)) * W + writes % (W - 1)),
                           grad_addr);
                writes++;
            end
            if (done) begin
                check_bit("grad_wr in cycle before done", 1'b1, prev_wr);
                dones++;
            end
            prev_wr = grad_wr;
        end
        check_count("img_rd cycles", NPIX, reads);
        check_count("grad_wr pulses", (W - 1) * (W - 1), writes);
        // everything quiet after the run
        repeat (W) begin
            @(negedge clk);
            check_bit("done", 1'b0, done);
            check_bit("grad_wr", 1'b0, grad_wr);
            check_bit("img_rd", 1'b0, img_rd);
        end
        verify_grads(1'b0);
    endtask

    task automatic test_reset_mid_run();
        fill_random();
        apply_reset();
        repeat (NPIX / 2) @(negedge clk);
        check_bit("img_rd", 1'b1, img_rd);
        reset = 1'b1;
        clear_grad = 1'b1;
        @(negedge clk);
        check_bit("img_rd", 1'b0, img_rd);
        check_bit("grad_wr", 1'b0, grad_wr);
        check_bit("done", 1'b0, done);
        @(negedge clk);
        // new image loaded while the engine is held in reset
        fill_random();
        reset = 1'b0;
        clear_grad = 1'b0;
        wait_done();
        verify_grads(1'b0);
    endtask

    // --------------------
    // watchdog and main
    // --------------------
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: done never arrived within %0d ns", TIMEOUT_NS);
        abort_run();
    end

    initial begin
        seed = 32'hfd538081;
        test_image(0);
        test_image(1);
        test_image(2);
        test_write_pattern();
        test_reset_mid_run();
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: flist.f
common/ig_data_pkg.sv
common/ig_ctrl_pkg.sv
gradient/line_buffer.sv
gradient/grad_calc.sv
hdl/img_fetch.sv
hdl/ig.sv
test/tb_clock.sv
test/ig_props.sv
test/ig_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= ig_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
